/* source/lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// DCCM window, 64 KB
`define LSU_DCCM_BASE 32'hF004_0000
`define LSU_DCCM_SIZE 32'h0001_0000

// PIC register window, 32 KB
`define LSU_PIC_BASE 32'hF00C_0000
`define LSU_PIC_SIZE 32'h0000_8000

// Fault cause codes reported in the error packet
`define LSU_CAUSE_MISALIGNED   4'd1
`define LSU_CAUSE_REGION_CROSS 4'd2
`define LSU_CAUSE_PIC_SIZE     4'd3

`endif

/* source/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [11:0] offset_t;
   // 0 byte, 1 half, 2 word
   typedef logic [1:0]  size_t;
   typedef logic [3:0]  cause_t;

   typedef struct packed {
      logic  valid;
      logic  dma;
      logic  load;
      logic  store;
      logic  unsign;
      size_t size;
   } lsu_pkt_t;

   typedef struct packed {
      logic in_dccm;
      logic in_pic;
      logic external;
   } lsu_region_t;

   typedef struct packed {
      logic   access;
      logic   misaligned;
      cause_t cause;
   } lsu_fault_t;

   typedef struct packed {
      logic   exc_valid;
      // 1 for a store
      logic   inst_type;
      // 0 misaligned, 1 access fault
      logic   exc_type;
      cause_t cause;
      addr_t  addr;
   } lsu_error_pkt_t;

endpackage

`default_nettype wire

/* source/lsu_req_select.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_req_select import lsu_pkg::*; (
   input  lsu_pkt_t core_pkt,
   input  logic     core_valid_raw,
   input  addr_t    rs1,
   input  offset_t  offset,
   input  data_t    rs2,
   input  logic     flush_m_up,

   input  logic     dma_req,
   input  addr_t    dma_addr,
   input  size_t    dma_size,
   input  logic     dma_write,
   input  data_t    dma_wdata,

   output lsu_pkt_t pkt_d,
   output addr_t    addr_d,
   output addr_t    end_addr_d,
   output data_t    store_data_d
);

   lsu_pkt_t    dma_pkt;
   addr_t       base_d;
   offset_t     off_d;
   logic [1:0]  size_m1;
   logic [12:0] end_off_d;
   data_t       dma_wdata_shifted;

   always_comb begin
      dma_pkt        = '0;
      dma_pkt.valid  = dma_req;
      dma_pkt.dma    = 1'b1;
      dma_pkt.load   = ~dma_write;
      dma_pkt.store  = dma_write;
      dma_pkt.unsign = 1'b0;
      dma_pkt.size   = dma_size;
   end

   // Core owns the address path whenever its raw valid is up
   always_comb begin
      pkt_d       = core_valid_raw ? core_pkt : dma_pkt;
      pkt_d.valid = (core_pkt.valid & ~flush_m_up) | dma_req;
   end

   // DMA carries a full address, so its offset is forced to zero
   assign base_d = core_valid_raw ? rs1 : dma_addr;
   assign off_d  = offset & {12{core_valid_raw}};

   assign addr_d = base_d + {{20{off_d[11]}}, off_d};

   // Last byte touched: half adds 1, word adds 3
   assign size_m1    = (pkt_d.size == 2'd2) ? 2'd3 : pkt_d.size;
   assign end_off_d  = {off_d[11], off_d} + {11'b0, size_m1};
   assign end_addr_d = base_d + {{19{end_off_d[12]}}, end_off_d};

   // Align DMA write data to bit 0 like a core store
   assign dma_wdata_shifted = dma_wdata >> {dma_addr[1:0], 3'b000};
   assign store_data_d      = dma_req ? dma_wdata_shifted : rs2;

   // Doubleword DMA is not supported on this path
   always_comb begin
      if (dma_req) begin
         assert final (dma_size != 2'd3)
            else $error("DMA request with doubleword size");
      end
   end

endmodule

`default_nettype wire

/* source/lsu_addr_check.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_addr_check import lsu_pkg::*; (
   input  addr_t       addr_d,
   input  addr_t       end_addr_d,
   input  lsu_pkt_t    pkt_d,

   output lsu_region_t region_d,
   output lsu_fault_t  fault_d
);

   logic start_dccm;
   logic start_pic;
   logic end_dccm;
   logic end_pic;
   logic region_cross;
   logic pic_not_word;
   logic unaligned;
   logic core_chk;

   function automatic logic in_window(addr_t a, addr_t base, addr_t size);
      in_window = (a - base) < size;
   endfunction

   assign start_dccm = in_window(addr_d, `LSU_DCCM_BASE, `LSU_DCCM_SIZE);
   assign start_pic  = in_window(addr_d, `LSU_PIC_BASE, `LSU_PIC_SIZE);
   assign end_dccm   = in_window(end_addr_d, `LSU_DCCM_BASE, `LSU_DCCM_SIZE);
   assign end_pic    = in_window(end_addr_d, `LSU_PIC_BASE, `LSU_PIC_SIZE);

   // Region follows the start address
   assign region_d.in_dccm  = start_dccm;
   assign region_d.in_pic   = start_pic;
   assign region_d.external = ~start_dccm & ~start_pic;

   assign region_cross = (start_dccm != end_dccm) | (start_pic != end_pic);
   assign pic_not_word = start_pic & (pkt_d.size != 2'd2);

   assign unaligned = ((pkt_d.size == 2'd1) & addr_d[0]) |
                      ((pkt_d.size == 2'd2) & (addr_d[1:0] != 2'b00));

   // DMA requests are never faulted here
   assign core_chk = pkt_d.valid & ~pkt_d.dma;

   always_comb begin
      fault_d = '0;
      if (core_chk) begin
         if (region_cross) begin
            fault_d.access = 1'b1;
            fault_d.cause  = `LSU_CAUSE_REGION_CROSS;
         end else if (pic_not_word) begin
            fault_d.access = 1'b1;
            fault_d.cause  = `LSU_CAUSE_PIC_SIZE;
         end else if (unaligned & ~start_dccm) begin
            // DCCM handles unaligned accesses itself
            fault_d.misaligned = 1'b1;
            fault_d.cause      = `LSU_CAUSE_MISALIGNED;
         end
      end
   end

   // Overlapping windows would make the region decode ambiguous
   always_comb begin
      assert final ($onehot0(region_d))
         else $error("More than one region flag set for 0x%08h", addr_d);
   end

endmodule

`default_nettype wire

/* source/lsu_stage_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_stage_pipe import lsu_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        flush_m_up,

   input  lsu_pkt_t    pkt_d,
   input  addr_t       addr_d,
   input  addr_t       end_addr_d,
   input  lsu_region_t region_d,
   input  lsu_fault_t  fault_d,
   input  data_t       store_data_d,

   output lsu_pkt_t    pkt_m,
   output lsu_pkt_t    pkt_r,
   output addr_t       addr_m,
   output addr_t       addr_r,
   output addr_t       end_addr_m,
   output addr_t       end_addr_r,
   output lsu_region_t region_m,
   output lsu_region_t region_r,
   output lsu_fault_t  fault_m,
   output data_t       store_data_m
);

   lsu_pkt_t pkt_m_in;
   lsu_pkt_t pkt_r_in;

   // A flush kills core packets in flight, DMA always completes
   always_comb begin
      pkt_m_in       = pkt_d;
      pkt_m_in.valid = pkt_d.valid & ~(flush_m_up & ~pkt_d.dma);
      pkt_r_in       = pkt_m;
      pkt_r_in.valid = pkt_m.valid & ~(flush_m_up & ~pkt_m.dma);
   end

   // Only the valid bits are cleared
   always_ff @(posedge clk) begin
      pkt_m <= pkt_m_in;
      pkt_r <= pkt_r_in;
      if (rst) begin
         pkt_m.valid <= 1'b0;
         pkt_r.valid <= 1'b0;
      end
   end

   // D to M
   always_ff @(posedge clk) begin
      addr_m       <= addr_d;
      end_addr_m   <= end_addr_d;
      region_m     <= region_d;
      fault_m      <= fault_d;
      store_data_m <= store_data_d;
   end

   // M to R
   always_ff @(posedge clk) begin
      addr_r     <= addr_m;
      end_addr_r <= end_addr_m;
      region_r   <= region_m;
   end

   a_dma_reaches_r: assert property (
      @(posedge clk) disable iff (rst)
      (pkt_m.valid && pkt_m.dma) |=> pkt_r.valid
   ) else $error("DMA packet dropped between M and R");

endmodule

`default_nettype wire

/* source/lsu_result_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_result_ctl import lsu_pkg::*; (
   input  logic           clk,
   input  logic           rst,
   input  logic           flush_m_up,
   input  logic           flush_r,

   input  lsu_pkt_t       pkt_m,
   input  lsu_pkt_t       pkt_r,
   input  addr_t          addr_m,
   input  lsu_region_t    region_m,
   input  lsu_fault_t     fault_m,
   input  data_t          ld_data_m,
   input  data_t          bus_read_data_m,

   output data_t          result_m,
   output logic           exc_m,
   output lsu_error_pkt_t error_pkt_r,
   output logic           commit_r
);

   data_t          ld_datafn_m;
   lsu_error_pkt_t error_pkt_m;

   // External loads return on the bus, everything else from DCCM
   assign ld_datafn_m = region_m.external ? bus_read_data_m : ld_data_m;

   always_comb begin
      case (pkt_m.size)
         2'd0: begin
            if (pkt_m.unsign)
               result_m = {24'b0, ld_datafn_m[7:0]};
            else
               result_m = {{24{ld_datafn_m[7]}}, ld_datafn_m[7:0]};
         end
         2'd1: begin
            if (pkt_m.unsign)
               result_m = {16'b0, ld_datafn_m[15:0]};
            else
               result_m = {{16{ld_datafn_m[15]}}, ld_datafn_m[15:0]};
         end
         default: result_m = ld_datafn_m;
      endcase
   end

   assign exc_m = fault_m.access | fault_m.misaligned;

   // Error packet is built at M and handed to the trap logic at R
   always_comb begin
      error_pkt_m.exc_valid = exc_m & pkt_m.valid & ~pkt_m.dma & ~flush_m_up;
      error_pkt_m.inst_type = pkt_m.store;
      error_pkt_m.exc_type  = ~fault_m.misaligned;
      error_pkt_m.cause     = fault_m.cause;
      error_pkt_m.addr      = addr_m;
   end

   always_ff @(posedge clk) begin
      error_pkt_r <= error_pkt_m;
      if (rst) begin
         error_pkt_r.exc_valid <= 1'b0;
      end
   end

   // DMA never retires an instruction
   assign commit_r = pkt_r.valid & (pkt_r.load | pkt_r.store) & ~flush_r & ~pkt_r.dma;

endmodule

`default_nettype wire

/* source/lsu_lsc_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_lsc_ctl import lsu_pkg::*; (
   input  logic           clk,
   input  logic           rst,
   input  logic           flush_m_up,
   input  logic           flush_r,

   input  lsu_pkt_t       core_pkt,
   input  logic           core_valid_raw,
   input  addr_t          rs1,
   input  offset_t        offset,
   input  data_t          rs2,

   input  logic           dma_req,
   input  addr_t          dma_addr,
   input  size_t          dma_size,
   input  logic           dma_write,
   input  data_t          dma_wdata,

   input  data_t          ld_data_m,
   input  data_t          bus_read_data_m,

   output addr_t          lsu_addr_d,
   output addr_t          lsu_addr_m,
   output addr_t          lsu_addr_r,
   output addr_t          end_addr_d,
   output addr_t          end_addr_m,
   output addr_t          end_addr_r,
   output logic           addr_in_dccm_d,
   output logic           addr_in_dccm_m,
   output logic           addr_in_dccm_r,
   output logic           addr_in_pic_d,
   output logic           addr_in_pic_m,
   output logic           addr_in_pic_r,
   output logic           addr_external_m,
   output lsu_pkt_t       lsu_pkt_d,
   output lsu_pkt_t       lsu_pkt_m,
   output lsu_pkt_t       lsu_pkt_r,
   output data_t          store_data_m,
   output data_t          lsu_result_m,
   output logic           lsu_exc_m,
   output lsu_error_pkt_t lsu_error_pkt_r,
   output logic           lsu_commit_r
);

   data_t       store_data_d;
   lsu_region_t region_d;
   lsu_region_t region_m;
   lsu_region_t region_r;
   lsu_fault_t  fault_d;
   lsu_fault_t  fault_m;

   assign addr_in_dccm_d  = region_d.in_dccm;
   assign addr_in_dccm_m  = region_m.in_dccm;
   assign addr_in_dccm_r  = region_r.in_dccm;
   assign addr_in_pic_d   = region_d.in_pic;
   assign addr_in_pic_m   = region_m.in_pic;
   assign addr_in_pic_r   = region_r.in_pic;
   assign addr_external_m = region_m.external;

   lsu_req_select req_select (
      .core_pkt       (core_pkt),
      .core_valid_raw (core_valid_raw),
      .rs1            (rs1),
      .offset         (offset),
      .rs2            (rs2),
      .flush_m_up     (flush_m_up),
      .dma_req        (dma_req),
      .dma_addr       (dma_addr),
      .dma_size       (dma_size),
      .dma_write      (dma_write),
      .dma_wdata      (dma_wdata),
      .pkt_d          (lsu_pkt_d),
      .addr_d         (lsu_addr_d),
      .end_addr_d     (end_addr_d),
      .store_data_d   (store_data_d)
   );

   lsu_addr_check addr_check (
      .addr_d     (lsu_addr_d),
      .end_addr_d (end_addr_d),
      .pkt_d      (lsu_pkt_d),
      .region_d   (region_d),
      .fault_d    (fault_d)
   );

   lsu_stage_pipe stage_pipe (
      .clk          (clk),
      .rst          (rst),
      .flush_m_up   (flush_m_up),
      .pkt_d        (lsu_pkt_d),
      .addr_d       (lsu_addr_d),
      .end_addr_d   (end_addr_d),
      .region_d     (region_d),
      .fault_d      (fault_d),
      .store_data_d (store_data_d),
      .pkt_m        (lsu_pkt_m),
      .pkt_r        (lsu_pkt_r),
      .addr_m       (lsu_addr_m),
      .addr_r       (lsu_addr_r),
      .end_addr_m   (end_addr_m),
      .end_addr_r   (end_addr_r),
      .region_m     (region_m),
      .region_r     (region_r),
      .fault_m      (fault_m),
      .store_data_m (store_data_m)
   );

   lsu_result_ctl result_ctl (
      .clk             (clk),
      .rst             (rst),
      .flush_m_up      (flush_m_up),
      .flush_r         (flush_r),
      .pkt_m           (lsu_pkt_m),
      .pkt_r           (lsu_pkt_r),
      .addr_m          (lsu_addr_m),
      .region_m        (region_m),
      .fault_m         (fault_m),
      .ld_data_m       (ld_data_m),
      .bus_read_data_m (bus_read_data_m),
      .result_m        (lsu_result_m),
      .exc_m           (lsu_exc_m),
      .error_pkt_r     (lsu_error_pkt_r),
      .commit_r        (lsu_commit_r)
   );

endmodule

`default_nettype wire

/* tb/lsu_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_clk_gen (
   output logic clk,
   output logic rst
);

   // 100 ns period
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Reset spans the first three rising edges
   initial begin
      rst = 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

/* tb/lsu_lsc_ctl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_lsc_ctl_tb import lsu_pkg::*; ();

   typedef struct packed {
      logic       src;
      logic       ld;
      logic       st;
      logic       uns;
      size_t      size;
      addr_t      base;
      offset_t    off;
      data_t      wdata;
      data_t      rdata;
      logic       fm;
      logic       fr;
      addr_t      exp_addr;
      logic [1:0] region;
      data_t      exp_result;
      logic       exc;
      cause_t     cause;
      logic       commit;
   } test_vec_t;

   logic           clk;
   logic           rst;
   logic           flush_m_up;
   logic           flush_r;
   lsu_pkt_t       core_pkt;
   logic           core_valid_raw;
   addr_t          rs1;
   offset_t        offset;
   data_t          rs2;
   logic           dma_req;
   addr_t          dma_addr;
   size_t          dma_size;
   logic           dma_write;
   data_t          dma_wdata;
   data_t          ld_data_m;
   data_t          bus_read_data_m;

   addr_t          lsu_addr_d;
   addr_t          lsu_addr_m;
   addr_t          lsu_addr_r;
   addr_t          end_addr_d;
   addr_t          end_addr_m;
   addr_t          end_addr_r;
   logic           addr_in_dccm_d;
   logic           addr_in_dccm_m;
   logic           addr_in_dccm_r;
   logic           addr_in_pic_d;
   logic           addr_in_pic_m;
   logic           addr_in_pic_r;
   logic           addr_external_m;
   lsu_pkt_t       lsu_pkt_d;
   lsu_pkt_t       lsu_pkt_m;
   lsu_pkt_t       lsu_pkt_r;
   data_t          store_data_m;
   data_t          lsu_result_m;
   logic           lsu_exc_m;
   lsu_error_pkt_t lsu_error_pkt_r;
   logic           lsu_commit_r;

   string     names[$];
   test_vec_t tests[$];
   string     cur_name;
   int        test_errs;
   int        n_pass;
   int        n_fail;
   int        cycles;
   int        cycle_limit;

   lsu_clk_gen clk_gen (
      .clk (clk),
      .rst (rst)
   );

   lsu_lsc_ctl DUT (.*);

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   task automatic check_addr(input string what, input addr_t exp, input addr_t act);
      if (exp !== act) begin
         $display("FAIL %s %s: expected %08h, actual %08h", cur_name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_data(input string what, input data_t exp, input data_t act);
      if (exp !== act) begin
         $display("FAIL %s %s: expected %08h, actual %08h", cur_name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_pkt(input string what, input lsu_pkt_t exp, input lsu_pkt_t act);
      if (exp !== act) begin
         $display("FAIL %s %s: expected %02h, actual %02h", cur_name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_error(input string what, input lsu_error_pkt_t exp,
                              input lsu_error_pkt_t act);
      if (exp !== act) begin
         $display("FAIL %s %s: expected %010h, actual %010h", cur_name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (exp !== act) begin
         $display("FAIL %s %s: expected %b, actual %b", cur_name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic report_test();
      if (test_errs == 0) begin
         $display("PASS %s", cur_name);
         n_pass++;
      end else begin
         $display("FAIL %s: %0d mismatches", cur_name, test_errs);
         n_fail++;
      end
   endtask

   task automatic drive_idle();
      core_pkt       <= '0;
      core_valid_raw <= 1'b0;
      rs1            <= '0;
      offset         <= '0;
      rs2            <= '0;
      dma_req        <= 1'b0;
      dma_addr       <= '0;
      dma_size       <= '0;
      dma_write      <= 1'b0;
      dma_wdata      <= '0;
   endtask

   task automatic drive_request(input test_vec_t t);
      lsu_pkt_t req_pkt;
      req_pkt.valid  = 1'b1;
      req_pkt.dma    = 1'b0;
      req_pkt.load   = t.ld;
      req_pkt.store  = t.st;
      req_pkt.unsign = t.uns;
      req_pkt.size   = t.size;
      drive_idle();
      if (t.src) begin
         dma_req   <= 1'b1;
         dma_addr  <= t.base;
         dma_size  <= t.size;
         dma_write <= t.st;
         dma_wdata <= t.wdata;
         offset    <= t.off;
      end else begin
         core_pkt       <= req_pkt;
         core_valid_raw <= 1'b1;
         rs1            <= t.base;
         offset         <= t.off;
         rs2            <= t.wdata;
      end
   endtask

   task automatic read_tests();
      int          fd;
      int          code;
      string       line;
      string       nm;
      logic [31:0] f [17];
      test_vec_t   t;
      fd = $fopen("tb/lsu_tests.txt", "r");
      if (fd == 0) begin
         $display("Cannot open tb/lsu_tests.txt");
         return;
      end
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", nm,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
         // Header and blank lines do not parse as a full row
         if (code == 18) begin
            t.src        = f[0][0];
            t.ld         = f[1][0];
            t.st         = f[2][0];
            t.uns        = f[3][0];
            t.size       = f[4][1:0];
            t.base       = f[5];
            t.off        = f[6][11:0];
            t.wdata      = f[7];
            t.rdata      = f[8];
            t.fm         = f[9][0];
            t.fr         = f[10][0];
            t.exp_addr   = f[11];
            t.region     = f[12][1:0];
            t.exp_result = f[13];
            t.exc        = f[14][0];
            t.cause      = f[15][3:0];
            t.commit     = f[16][0];
            names.push_back(nm);
            tests.push_back(t);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_test(input string name, input test_vec_t t);
      lsu_pkt_t       exp_pkt;
      lsu_pkt_t       exp_pkt_r;
      lsu_error_pkt_t exp_err;
      addr_t          exp_end;
      data_t          exp_store;
      cur_name  = name;
      test_errs = 0;

      exp_pkt.valid  = 1'b1;
      exp_pkt.dma    = t.src;
      exp_pkt.load   = t.ld;
      exp_pkt.store  = t.st;
      exp_pkt.unsign = t.uns;
      exp_pkt.size   = t.size;
      // A core packet dies at M to R under flush, DMA goes on
      exp_pkt_r       = exp_pkt;
      exp_pkt_r.valid = ~(t.fm & ~t.src);

      // Last byte of a 1, 2 or 4 byte access
      exp_end   = t.exp_addr + (32'd1 << t.size) - 32'd1;
      exp_store = t.src ? (t.wdata >> (8 * t.exp_addr[1:0])) : t.wdata;

      exp_err.exc_valid = ~t.src & ~t.fm;
      exp_err.inst_type = t.st;
      exp_err.exc_type  = (t.cause != `LSU_CAUSE_MISALIGNED);
      exp_err.cause     = t.cause;
      exp_err.addr      = t.exp_addr;

      @(posedge clk);
      drive_request(t);
      flush_r <= 1'b0;

      @(negedge clk);
      check_addr("addr_d", t.exp_addr, lsu_addr_d);
      check_addr("end_addr_d", exp_end, end_addr_d);
      check_bit("dccm_d", t.region == 2'd1, addr_in_dccm_d);
      check_bit("pic_d", t.region == 2'd2, addr_in_pic_d);
      check_pkt("pkt_d", exp_pkt, lsu_pkt_d);

      // The same request enters D again while the flush is up
      @(posedge clk);
      drive_request(t);
      flush_m_up      <= t.fm;
      ld_data_m       <= t.rdata;
      bus_read_data_m <= ~t.rdata;

      @(negedge clk);
      check_addr("addr_m", t.exp_addr, lsu_addr_m);
      check_addr("end_addr_m", exp_end, end_addr_m);
      check_bit("dccm_m", t.region == 2'd1, addr_in_dccm_m);
      check_bit("pic_m", t.region == 2'd2, addr_in_pic_m);
      check_bit("external_m", t.region == 2'd0, addr_external_m);
      check_pkt("pkt_m", exp_pkt, lsu_pkt_m);
      check_data("store_data_m", exp_store, store_data_m);
      if (t.ld)
         check_data("result_m", t.exp_result, lsu_result_m);
      check_bit("exc_m", t.exc, lsu_exc_m);

      @(posedge clk);
      drive_idle();
      flush_m_up <= 1'b0;
      flush_r    <= t.fr;

      @(negedge clk);
      check_addr("addr_r", t.exp_addr, lsu_addr_r);
      check_addr("end_addr_r", exp_end, end_addr_r);
      check_bit("dccm_r", t.region == 2'd1, addr_in_dccm_r);
      check_bit("pic_r", t.region == 2'd2, addr_in_pic_r);
      check_pkt("pkt_r", exp_pkt_r, lsu_pkt_r);
      // Second copy went from D to M under the flush
      check_bit("flushed_valid_m", exp_pkt_r.valid, lsu_pkt_m.valid);
      if (t.exc)
         check_error("error_pkt_r", exp_err, lsu_error_pkt_r);
      else
         check_bit("exc_valid_r", 1'b0, lsu_error_pkt_r.exc_valid);
      check_bit("commit_r", t.commit, lsu_commit_r);
      report_test();
   endtask

   initial begin
      n_pass          = 0;
      n_fail          = 0;
      cycles          = 0;
      cycle_limit     = 0;
      flush_m_up      = 1'b0;
      flush_r         = 1'b0;
      ld_data_m       = '0;
      bus_read_data_m = '0;
      drive_idle();

      read_tests();
      cycle_limit = tests.size() * 6 + 20;

      wait (rst === 1'b1);
      wait (rst === 1'b0);
      cur_name  = "reset";
      test_errs = 0;
      @(negedge clk);
      check_bit("pkt_m.valid", 1'b0, lsu_pkt_m.valid);
      check_bit("pkt_r.valid", 1'b0, lsu_pkt_r.valid);
      check_bit("commit_r", 1'b0, lsu_commit_r);
      check_bit("exc_m", 1'b0, lsu_exc_m);
      check_bit("exc_valid_r", 1'b0, lsu_error_pkt_r.exc_valid);
      report_test();

      foreach (tests[i])
         run_test(names[i], tests[i]);

      if (tests.size() == 0)
         $display("No tests were read from tb/lsu_tests.txt");
      $display("Tests: %0d run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
      if (n_fail == 0 && tests.size() > 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/lsu_tests.txt */
# name src ld st uns size base off wdata rdata flush_m flush_r
# then expected: address region(0 ext 1 dccm 2 pic) result exc cause commit; bus data is ~rdata
ld_w_dccm    0 1 0 0 2 F0040100 010 00000000 8899AABB 0 0 F0040110 1 8899AABB 0 0 1
ld_b_sext    0 1 0 0 0 F0040010 FF0 00000000 000000F5 0 0 F0040000 1 FFFFFFF5 0 0 1
ld_b_zext    0 1 0 1 0 F0040020 003 00000000 123456F5 0 0 F0040023 1 000000F5 0 0 1
ld_h_sext    0 1 0 0 1 F0040200 002 00000000 00008001 0 0 F0040202 1 FFFF8001 0 0 1
ld_h_zext    0 1 0 1 1 F0040200 004 00000000 11118001 0 0 F0040204 1 00008001 0 0 1
ld_w_ext     0 1 0 0 2 20000000 100 00000000 11223344 0 0 20000100 0 EEDDCCBB 0 0 1
ld_h_ext     0 1 0 0 1 20000000 006 00000000 FFFF7FFF 0 0 20000006 0 FFFF8000 0 0 1
ld_w_pic     0 1 0 0 2 F00C0000 004 00000000 00000055 0 0 F00C0004 2 00000055 0 0 1
st_w_dccm    0 0 1 0 2 F0041000 008 CAFEF00D 00000000 0 0 F0041008 1 00000000 0 0 1
misal_ld_w   0 1 0 0 2 20000000 002 00000000 00000000 0 0 20000002 0 FFFFFFFF 1 1 1
misal_st_h   0 0 1 0 1 30000000 001 0000BEEF 00000000 0 0 30000001 0 00000000 1 1 1
dccm_unal    0 1 0 0 2 F0040000 001 00000000 01020304 0 0 F0040001 1 01020304 0 0 1
cross_up     0 1 0 0 2 F004FFFC 002 00000000 A5A5A5A5 0 0 F004FFFE 1 A5A5A5A5 1 2 1
cross_down   0 1 0 0 2 F0040002 FFC 00000000 00000000 0 0 F003FFFE 0 FFFFFFFF 1 2 1
pic_byte     0 1 0 1 0 F00C0000 010 00000000 000000AB 0 0 F00C0010 2 000000AB 1 3 1
flush_m      0 1 0 0 2 F0040000 000 00000000 12345678 1 0 F0040000 1 12345678 0 0 0
flush_m_exc  0 1 0 0 1 20000000 001 00000000 00000000 1 0 20000001 0 FFFFFFFF 1 1 0
flush_r      0 1 0 0 2 F0040040 000 00000000 00000001 0 1 F0040040 1 00000001 0 0 0
dma_rd       1 1 0 0 2 F0040080 7FF 00000000 00C0FFEE 0 0 F0040080 1 00C0FFEE 0 0 0
dma_wr_b     1 0 1 0 0 F0040003 000 AB000000 00000000 0 0 F0040003 1 00000000 0 0 0
dma_wr_flush 1 0 1 0 1 F0040002 000 12345678 00000000 1 1 F0040002 1 00000000 0 0 0
dma_rd_unal  1 1 0 0 2 40000001 000 00000000 00000000 0 0 40000001 0 FFFFFFFF 0 0 0

/* vlog.f */
+incdir+source
source/lsu_pkg.sv
source/lsu_req_select.sv
source/lsu_addr_check.sv
source/lsu_stage_pipe.sv
source/lsu_result_ctl.sv
source/lsu_lsc_ctl.sv
tb/lsu_clk_gen.sv
tb/lsu_lsc_ctl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_lsc_ctl_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass message shows up in the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
